/* hdl/cpu_pkg.sv */
// Shared widths, instruction fields and ALU/branch codes for the pipeline core, referenced by scope
package cpu_pkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0]  reg_addr_t;
	typedef logic [29:0] word_addr_t;
	typedef logic [3:0]  alu_op_t;
	typedef logic [1:0]  br_kind_t;

	// alu operations
	localparam alu_op_t ALU_ADD  = 4'd0;
	localparam alu_op_t ALU_SUB  = 4'd1;
	localparam alu_op_t ALU_AND  = 4'd2;
	localparam alu_op_t ALU_OR   = 4'd3;
	localparam alu_op_t ALU_XOR  = 4'd4;
	localparam alu_op_t ALU_NOR  = 4'd5;
	localparam alu_op_t ALU_SLT  = 4'd6;
	localparam alu_op_t ALU_SLTU = 4'd7;
	localparam alu_op_t ALU_LUI  = 4'd8;

	// branch kinds, jump covers J, JAL and JR
	localparam br_kind_t BR_NONE = 2'd0;
	localparam br_kind_t BR_EQ   = 2'd1;
	localparam br_kind_t BR_NE   = 2'd2;
	localparam br_kind_t BR_JUMP = 2'd3;

	// ------------------------------------------------------------------------
	// opcode field
	localparam logic [5:0] OP_SPECIAL = 6'h00;
	localparam logic [5:0] OP_J       = 6'h02;
	localparam logic [5:0] OP_JAL     = 6'h03;
	localparam logic [5:0] OP_BEQ     = 6'h04;
	localparam logic [5:0] OP_BNE     = 6'h05;
	localparam logic [5:0] OP_ADDIU   = 6'h09;
	localparam logic [5:0] OP_SLTI    = 6'h0a;
	localparam logic [5:0] OP_SLTIU   = 6'h0b;
	localparam logic [5:0] OP_ANDI    = 6'h0c;
	localparam logic [5:0] OP_ORI     = 6'h0d;
	localparam logic [5:0] OP_XORI    = 6'h0e;
	localparam logic [5:0] OP_LUI     = 6'h0f;
	localparam logic [5:0] OP_LW      = 6'h23;
	localparam logic [5:0] OP_SW      = 6'h2b;

	// function field of OP_SPECIAL
	localparam logic [5:0] FN_JR   = 6'h08;
	localparam logic [5:0] FN_ADDU = 6'h21;
	localparam logic [5:0] FN_SUBU = 6'h23;
	localparam logic [5:0] FN_AND  = 6'h24;
	localparam logic [5:0] FN_OR   = 6'h25;
	localparam logic [5:0] FN_XOR  = 6'h26;
	localparam logic [5:0] FN_NOR  = 6'h27;
	localparam logic [5:0] FN_SLT  = 6'h2a;
	localparam logic [5:0] FN_SLTU = 6'h2b;

	localparam reg_addr_t LINK_REG     = 5'd31;
	localparam word_t     RESET_VECTOR = 32'h0000_0000;

endpackage

/* hdl/cpu_fetch.sv */
// Fetch stage of the core, holding the PC, the instruction bus request and the fetch register
module cpu_fetch (
	input  logic                clk,
	input  logic                reset,
	input  logic                stall,
	input  logic                redirect_i,
	input  cpu_pkg::word_t      redirect_pc_i,
	output logic                ibus_valid_o,
	input  logic                ibus_ready_i,
	output cpu_pkg::word_addr_t ibus_addr_o,
	input  cpu_pkg::word_t      ibus_rdata_i,
	output logic                busy_o,
	output logic                inst_valid_o,
	output cpu_pkg::word_t      inst_o,
	output cpu_pkg::word_t      pc_o
);
	cpu_pkg::word_t pc_q;
	logic           accept;

	assign ibus_addr_o = pc_q[31:2];
	assign accept      = ibus_valid_o & ibus_ready_i;
	assign busy_o      = ibus_valid_o & ~ibus_ready_i;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			ibus_valid_o <= 1'b0;
			pc_q         <= cpu_pkg::RESET_VECTOR;
			inst_valid_o <= 1'b0;
		end else begin
			ibus_valid_o <= 1'b1;
			// a word accepted under stall is dropped and read again
			if (!stall) begin
				inst_valid_o <= accept & ~redirect_i;
				if (redirect_i) begin
					pc_q <= redirect_pc_i;
				end else if (accept) begin
					pc_q <= pc_q + 32'd4;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!stall && accept) begin
			inst_o <= ibus_rdata_i;
			pc_o   <= pc_q;
		end
	end

endmodule

/* hdl/cpu_decode.sv */
// Decode stage of the core; turns an instruction into execute controls and the decode register
module cpu_decode (
	input  logic               clk,
	input  logic               reset,
	input  logic               stall,
	input  logic               flush_i,
	input  logic               inst_valid_i,
	input  cpu_pkg::word_t     inst_i,
	input  cpu_pkg::word_t     pc_i,
	output cpu_pkg::reg_addr_t rs_addr_o,
	output cpu_pkg::reg_addr_t rt_addr_o,
	input  cpu_pkg::word_t     rs_data_i,
	input  cpu_pkg::word_t     rt_data_i,
	output logic               ex_valid_o,
	output cpu_pkg::reg_addr_t ex_rs_o,
	output cpu_pkg::reg_addr_t ex_rt_o,
	output cpu_pkg::word_t     ex_rs_data_o,
	output cpu_pkg::word_t     ex_rt_data_o,
	output cpu_pkg::word_t     ex_imm_o,
	output logic               ex_imm_en_o,
	output cpu_pkg::alu_op_t   ex_alu_op_o,
	output cpu_pkg::br_kind_t  ex_br_kind_o,
	output logic               ex_br_reg_o,
	output logic               ex_link_o,
	output cpu_pkg::word_t     ex_pc_o,
	output cpu_pkg::word_t     ex_target_o,
	output logic               ex_mem_en_o,
	output logic               ex_mem_we_o,
	output logic               ex_dst_en_o,
	output cpu_pkg::reg_addr_t ex_dst_o
);
	logic [5:0]         op, fn;
	cpu_pkg::word_t     sext, imm, pc_next, target;
	cpu_pkg::alu_op_t   alu_op;
	cpu_pkg::br_kind_t  br_kind;
	cpu_pkg::reg_addr_t dst;
	logic               imm_en, zext, br_reg, link, mem_en, mem_we, dst_en, live;

	assign op        = inst_i[31:26];
	assign fn        = inst_i[5:0];
	assign rs_addr_o = inst_i[25:21];
	assign rt_addr_o = inst_i[20:16];
	assign live      = inst_valid_i & ~flush_i;

	assign sext    = {{16{inst_i[15]}}, inst_i[15:0]};
	assign imm     = zext ? {16'h0000, inst_i[15:0]} : sext;
	assign pc_next = pc_i + 32'd4;
	assign target  = (br_kind == cpu_pkg::BR_JUMP) ? {pc_next[31:28], inst_i[25:0], 2'b00}
	                                               : pc_next + {sext[29:0], 2'b00};

	// ------------------------------------------------------------------------
	// opcode and function decode, defaults suit an immediate ALU op
	always_comb begin
		alu_op  = cpu_pkg::ALU_ADD;
		imm_en  = 1'b1;
		zext    = 1'b0;
		br_kind = cpu_pkg::BR_NONE;
		br_reg  = 1'b0;
		link    = 1'b0;
		mem_en  = 1'b0;
		mem_we  = 1'b0;
		dst_en  = 1'b1;
		dst     = inst_i[20:16];
		case (op)
			cpu_pkg::OP_SPECIAL: begin
				imm_en = 1'b0;
				dst    = inst_i[15:11];
				case (fn)
					cpu_pkg::FN_ADDU: alu_op = cpu_pkg::ALU_ADD;
					cpu_pkg::FN_SUBU: alu_op = cpu_pkg::ALU_SUB;
					cpu_pkg::FN_AND:  alu_op = cpu_pkg::ALU_AND;
					cpu_pkg::FN_OR:   alu_op = cpu_pkg::ALU_OR;
					cpu_pkg::FN_XOR:  alu_op = cpu_pkg::ALU_XOR;
					cpu_pkg::FN_NOR:  alu_op = cpu_pkg::ALU_NOR;
					cpu_pkg::FN_SLT:  alu_op = cpu_pkg::ALU_SLT;
					cpu_pkg::FN_SLTU: alu_op = cpu_pkg::ALU_SLTU;
					cpu_pkg::FN_JR: begin
						br_kind = cpu_pkg::BR_JUMP;
						br_reg  = 1'b1;
						dst_en  = 1'b0;
					end
					default: dst_en = 1'b0;
				endcase
			end
			cpu_pkg::OP_J: begin
				br_kind = cpu_pkg::BR_JUMP;
				dst_en  = 1'b0;
			end
			cpu_pkg::OP_JAL: begin
				br_kind = cpu_pkg::BR_JUMP;
				link    = 1'b1;
				dst     = cpu_pkg::LINK_REG;
			end
			cpu_pkg::OP_BEQ: begin
				br_kind = cpu_pkg::BR_EQ;
				dst_en  = 1'b0;
			end
			cpu_pkg::OP_BNE: begin
				br_kind = cpu_pkg::BR_NE;
				dst_en  = 1'b0;
			end
			cpu_pkg::OP_ADDIU: alu_op = cpu_pkg::ALU_ADD;
			cpu_pkg::OP_SLTI:  alu_op = cpu_pkg::ALU_SLT;
			cpu_pkg::OP_SLTIU: alu_op = cpu_pkg::ALU_SLTU;
			cpu_pkg::OP_ANDI: begin
				alu_op = cpu_pkg::ALU_AND;
				zext   = 1'b1;
			end
			cpu_pkg::OP_ORI: begin
				alu_op = cpu_pkg::ALU_OR;
				zext   = 1'b1;
			end
			cpu_pkg::OP_XORI: begin
				alu_op = cpu_pkg::ALU_XOR;
				zext   = 1'b1;
			end
			cpu_pkg::OP_LUI: begin
				alu_op = cpu_pkg::ALU_LUI;
				zext   = 1'b1;
			end
			cpu_pkg::OP_LW: mem_en = 1'b1;
			cpu_pkg::OP_SW: begin
				mem_en = 1'b1;
				mem_we = 1'b1;
				dst_en = 1'b0;
			end
			// anything else retires as a no-op
			default: dst_en = 1'b0;
		endcase
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			ex_valid_o   <= 1'b0;
			ex_mem_en_o  <= 1'b0;
			ex_dst_en_o  <= 1'b0;
			ex_br_kind_o <= cpu_pkg::BR_NONE;
		end else if (!stall) begin
			ex_valid_o   <= live;
			ex_mem_en_o  <= live & mem_en;
			ex_dst_en_o  <= live & dst_en & (dst != '0);
			ex_br_kind_o <= br_kind;
		end
	end

	always_ff @(posedge clk) begin
		if (!stall) begin
			ex_rs_o      <= rs_addr_o;
			ex_rt_o      <= rt_addr_o;
			ex_rs_data_o <= rs_data_i;
			ex_rt_data_o <= rt_data_i;
			ex_imm_o     <= imm;
			ex_imm_en_o  <= imm_en;
			ex_alu_op_o  <= alu_op;
			ex_br_reg_o  <= br_reg;
			ex_link_o    <= link;
			ex_pc_o      <= pc_i;
			ex_target_o  <= target;
			ex_mem_we_o  <= mem_we;
			ex_dst_o     <= dst;
		end
	end

endmodule

/* hdl/cpu_gpr.sv */
// General purpose register file of the core, two reads and one write, r0 hard-wired to zero
module cpu_gpr (
	input  logic               clk,
	input  logic               reset,
	input  logic               we_i,
	input  cpu_pkg::reg_addr_t waddr_i,
	input  cpu_pkg::word_t     wdata_i,
	input  cpu_pkg::reg_addr_t raddr0_i,
	input  cpu_pkg::reg_addr_t raddr1_i,
	output cpu_pkg::word_t     rdata0_o,
	output cpu_pkg::word_t     rdata1_o
);
	cpu_pkg::word_t regs [1:31];
	logic           wr_en;

	assign wr_en = we_i && (waddr_i != '0);

	always_ff @(posedge clk) begin
		if (wr_en && !reset) begin
			regs[waddr_i] <= wdata_i;
		end
	end

	// write-through, decode sees the value retiring this cycle
	function automatic cpu_pkg::word_t read_port(input cpu_pkg::reg_addr_t addr);
		if (addr == '0) begin
			return '0;
		end
		return (wr_en && waddr_i == addr) ? wdata_i : regs[addr];
	endfunction

	always_comb begin
		rdata0_o = read_port(raddr0_i);
		rdata1_o = read_port(raddr1_i);
	end

endmodule

/* hdl/cpu_execute.sv */
// Execute stage of the core with operand forwarding, the ALU, branch resolution and its register
module cpu_execute (
	input  logic                clk,
	input  logic                reset,
	input  logic                stall,
	input  logic                ex_valid_i,
	input  cpu_pkg::reg_addr_t  ex_rs_i,
	input  cpu_pkg::reg_addr_t  ex_rt_i,
	input  cpu_pkg::word_t      ex_rs_data_i,
	input  cpu_pkg::word_t      ex_rt_data_i,
	input  cpu_pkg::word_t      ex_imm_i,
	input  logic                ex_imm_en_i,
	input  cpu_pkg::alu_op_t    ex_alu_op_i,
	input  cpu_pkg::br_kind_t   ex_br_kind_i,
	input  logic                ex_br_reg_i,
	input  logic                ex_link_i,
	input  cpu_pkg::word_t      ex_pc_i,
	input  cpu_pkg::word_t      ex_target_i,
	input  logic                ex_mem_en_i,
	input  logic                ex_mem_we_i,
	input  logic                ex_dst_en_i,
	input  cpu_pkg::reg_addr_t  ex_dst_i,
	input  logic                wb_en_i,
	input  cpu_pkg::reg_addr_t  wb_addr_i,
	input  cpu_pkg::word_t      wb_data_i,
	output logic                redirect_o,
	output cpu_pkg::word_t      redirect_pc_o,
	output logic                mem_valid_o,
	output logic                mem_we_o,
	output cpu_pkg::word_addr_t mem_addr_o,
	output cpu_pkg::word_t      mem_wdata_o,
	output logic                mem_load_o,
	output logic                mem_dst_en_o,
	output cpu_pkg::reg_addr_t  mem_dst_o,
	output cpu_pkg::word_t      mem_result_o
);
	cpu_pkg::word_t rs_val, rt_val, opb, alu_res;
	logic           taken;

	// youngest producer wins, a load in the next stage has no data yet
	function automatic cpu_pkg::word_t forward(input cpu_pkg::reg_addr_t r,
	                                           input cpu_pkg::word_t rf);
		return (mem_dst_en_o && !mem_load_o && mem_dst_o == r) ? mem_result_o :
		       (wb_en_i && wb_addr_i == r) ? wb_data_i : rf;
	endfunction

	always_comb begin
		rs_val = forward(ex_rs_i, ex_rs_data_i);
		rt_val = forward(ex_rt_i, ex_rt_data_i);
	end

	assign opb = ex_imm_en_i ? ex_imm_i : rt_val;

	always_comb begin
		case (ex_alu_op_i)
			cpu_pkg::ALU_SUB:  alu_res = rs_val - opb;
			cpu_pkg::ALU_AND:  alu_res = rs_val & opb;
			cpu_pkg::ALU_OR:   alu_res = rs_val | opb;
			cpu_pkg::ALU_XOR:  alu_res = rs_val ^ opb;
			cpu_pkg::ALU_NOR:  alu_res = ~(rs_val | opb);
			cpu_pkg::ALU_SLT:  alu_res = {31'd0, $signed(rs_val) < $signed(opb)};
			cpu_pkg::ALU_SLTU: alu_res = {31'd0, rs_val < opb};
			cpu_pkg::ALU_LUI:  alu_res = {opb[15:0], 16'h0000};
			default:           alu_res = rs_val + opb;
		endcase
	end

	always_comb begin
		case (ex_br_kind_i)
			cpu_pkg::BR_EQ:   taken = (rs_val == rt_val);
			cpu_pkg::BR_NE:   taken = (rs_val != rt_val);
			cpu_pkg::BR_JUMP: taken = 1'b1;
			default:          taken = 1'b0;
		endcase
	end

	// ------------------------------------------------------------------------
	// execute/memory register, a redirect squashes what sits behind it
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			redirect_o   <= 1'b0;
			mem_valid_o  <= 1'b0;
			mem_dst_en_o <= 1'b0;
		end else if (!stall) begin
			redirect_o   <= ex_valid_i & taken & ~redirect_o;
			mem_valid_o  <= ex_mem_en_i & ~redirect_o;
			mem_dst_en_o <= ex_dst_en_i & ~redirect_o;
		end
	end

	always_ff @(posedge clk) begin
		if (!stall) begin
			redirect_pc_o <= ex_br_reg_i ? rs_val : ex_target_i;
			mem_we_o      <= ex_mem_we_i;
			mem_load_o    <= ex_mem_en_i & ~ex_mem_we_i;
			mem_addr_o    <= alu_res[31:2];
			mem_wdata_o   <= rt_val;
			mem_dst_o     <= ex_dst_i;
			mem_result_o  <= ex_link_i ? ex_pc_i + 32'd4 : alu_res;
		end
	end

endmodule

/* hdl/cpu_memory.sv */
// Memory stage of the core; runs the data bus access and feeds the write-back port
module cpu_memory (
	input  logic                clk,
	input  logic                reset,
	input  logic                stall,
	input  logic                mem_valid_i,
	input  logic                mem_we_i,
	input  cpu_pkg::word_addr_t mem_addr_i,
	input  cpu_pkg::word_t      mem_wdata_i,
	input  logic                mem_load_i,
	input  logic                mem_dst_en_i,
	input  cpu_pkg::reg_addr_t  mem_dst_i,
	input  cpu_pkg::word_t      mem_result_i,
	output logic                dbus_valid_o,
	output logic                dbus_we_o,
	input  logic                dbus_ready_i,
	output cpu_pkg::word_addr_t dbus_addr_o,
	output cpu_pkg::word_t      dbus_wdata_o,
	input  cpu_pkg::word_t      dbus_rdata_i,
	output logic                busy_o,
	output logic                wb_en_o,
	output cpu_pkg::reg_addr_t  wb_addr_o,
	output cpu_pkg::word_t      wb_data_o
);
	logic           done_q;
	logic           handshake;
	cpu_pkg::word_t hold_q;

	assign dbus_valid_o = mem_valid_i & ~done_q;
	assign dbus_we_o    = dbus_valid_o & mem_we_i;
	assign dbus_addr_o  = mem_addr_i;
	assign dbus_wdata_o = mem_wdata_i;
	assign handshake    = dbus_valid_o & dbus_ready_i;
	assign busy_o       = dbus_valid_o & ~dbus_ready_i;

	// access finished while the fetch side still holds the core
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			done_q  <= 1'b0;
			wb_en_o <= 1'b0;
		end else if (!stall) begin
			done_q  <= 1'b0;
			wb_en_o <= mem_dst_en_i;
		end else if (handshake) begin
			done_q <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (handshake) begin
			hold_q <= dbus_rdata_i;
		end
		if (!stall) begin
			wb_addr_o <= mem_dst_i;
			wb_data_o <= !mem_load_i ? mem_result_i : (done_q ? hold_q : dbus_rdata_i);
		end
	end

endmodule

/* hdl/cpu_core.sv */
// Top level of the five-stage core; connect the instruction and data buses to memory models
module cpu_core (
	input  logic                clk,
	input  logic                reset,
	output logic                ibus_valid_o,
	input  logic                ibus_ready_i,
	output cpu_pkg::word_addr_t ibus_addr_o,
	input  cpu_pkg::word_t      ibus_rdata_i,
	output logic                dbus_valid_o,
	output logic                dbus_we_o,
	input  logic                dbus_ready_i,
	output cpu_pkg::word_addr_t dbus_addr_o,
	output cpu_pkg::word_t      dbus_wdata_o,
	input  cpu_pkg::word_t      dbus_rdata_i
);
	logic                fetch_busy, mem_busy, stall;
	logic                redirect;
	cpu_pkg::word_t      redirect_pc;
	logic                if_inst_valid;
	cpu_pkg::word_t      if_inst, if_pc;
	cpu_pkg::reg_addr_t  rs_addr, rt_addr;
	cpu_pkg::word_t      rs_data, rt_data;
	logic                ex_valid, ex_imm_en, ex_br_reg, ex_link;
	logic                ex_mem_en, ex_mem_we, ex_dst_en;
	cpu_pkg::reg_addr_t  ex_rs, ex_rt, ex_dst;
	cpu_pkg::word_t      ex_rs_data, ex_rt_data, ex_imm, ex_pc, ex_target;
	cpu_pkg::alu_op_t    ex_alu_op;
	cpu_pkg::br_kind_t   ex_br_kind;
	logic                mem_valid, mem_we, mem_load, mem_dst_en;
	cpu_pkg::word_addr_t mem_addr;
	cpu_pkg::word_t      mem_wdata, mem_result;
	cpu_pkg::reg_addr_t  mem_dst;
	logic                wb_en;
	cpu_pkg::reg_addr_t  wb_addr;
	cpu_pkg::word_t      wb_data;

	// any bus waiting on ready freezes every stage
	assign stall = fetch_busy | mem_busy;

	cpu_fetch u_fetch (
		.clk(clk), .reset(reset), .stall(stall),
		.redirect_i(redirect), .redirect_pc_i(redirect_pc),
		.ibus_valid_o(ibus_valid_o), .ibus_ready_i(ibus_ready_i),
		.ibus_addr_o(ibus_addr_o), .ibus_rdata_i(ibus_rdata_i),
		.busy_o(fetch_busy),
		.inst_valid_o(if_inst_valid), .inst_o(if_inst), .pc_o(if_pc)
	);

	cpu_decode u_decode (
		.clk(clk), .reset(reset), .stall(stall), .flush_i(redirect),
		.inst_valid_i(if_inst_valid), .inst_i(if_inst), .pc_i(if_pc),
		.rs_addr_o(rs_addr), .rt_addr_o(rt_addr), .rs_data_i(rs_data), .rt_data_i(rt_data),
		.ex_valid_o(ex_valid), .ex_rs_o(ex_rs), .ex_rt_o(ex_rt),
		.ex_rs_data_o(ex_rs_data), .ex_rt_data_o(ex_rt_data),
		.ex_imm_o(ex_imm), .ex_imm_en_o(ex_imm_en), .ex_alu_op_o(ex_alu_op),
		.ex_br_kind_o(ex_br_kind), .ex_br_reg_o(ex_br_reg), .ex_link_o(ex_link),
		.ex_pc_o(ex_pc), .ex_target_o(ex_target),
		.ex_mem_en_o(ex_mem_en), .ex_mem_we_o(ex_mem_we),
		.ex_dst_en_o(ex_dst_en), .ex_dst_o(ex_dst)
	);

	cpu_gpr u_gpr (
		.clk(clk), .reset(reset),
		.we_i(wb_en), .waddr_i(wb_addr), .wdata_i(wb_data),
		.raddr0_i(rs_addr), .raddr1_i(rt_addr),
		.rdata0_o(rs_data), .rdata1_o(rt_data)
	);

	cpu_execute u_execute (
		.clk(clk), .reset(reset), .stall(stall),
		.ex_valid_i(ex_valid), .ex_rs_i(ex_rs), .ex_rt_i(ex_rt),
		.ex_rs_data_i(ex_rs_data), .ex_rt_data_i(ex_rt_data),
		.ex_imm_i(ex_imm), .ex_imm_en_i(ex_imm_en), .ex_alu_op_i(ex_alu_op),
		.ex_br_kind_i(ex_br_kind), .ex_br_reg_i(ex_br_reg), .ex_link_i(ex_link),
		.ex_pc_i(ex_pc), .ex_target_i(ex_target),
		.ex_mem_en_i(ex_mem_en), .ex_mem_we_i(ex_mem_we),
		.ex_dst_en_i(ex_dst_en), .ex_dst_i(ex_dst),
		.wb_en_i(wb_en), .wb_addr_i(wb_addr), .wb_data_i(wb_data),
		.redirect_o(redirect), .redirect_pc_o(redirect_pc),
		.mem_valid_o(mem_valid), .mem_we_o(mem_we), .mem_addr_o(mem_addr),
		.mem_wdata_o(mem_wdata), .mem_load_o(mem_load),
		.mem_dst_en_o(mem_dst_en), .mem_dst_o(mem_dst), .mem_result_o(mem_result)
	);

	cpu_memory u_memory (
		.clk(clk), .reset(reset), .stall(stall),
		.mem_valid_i(mem_valid), .mem_we_i(mem_we), .mem_addr_i(mem_addr),
		.mem_wdata_i(mem_wdata), .mem_load_i(mem_load),
		.mem_dst_en_i(mem_dst_en), .mem_dst_i(mem_dst), .mem_result_i(mem_result),
		.dbus_valid_o(dbus_valid_o), .dbus_we_o(dbus_we_o), .dbus_ready_i(dbus_ready_i),
		.dbus_addr_o(dbus_addr_o), .dbus_wdata_o(dbus_wdata_o), .dbus_rdata_i(dbus_rdata_i),
		.busy_o(mem_busy),
		.wb_en_o(wb_en), .wb_addr_o(wb_addr), .wb_data_o(wb_data)
	);

endmodule

/* tests/cpu_core_assertions.sv */
// Bus protocol assertions for the pipeline core, bound into cpu_core by the testbench
module cpu_core_assertions (
	input logic                clk,
	input logic                reset,
	input logic                ibus_valid_o,
	input logic                ibus_ready_i,
	input cpu_pkg::word_addr_t ibus_addr_o,
	input logic                dbus_valid_o,
	input logic                dbus_we_o,
	input logic                dbus_ready_i,
	input cpu_pkg::word_addr_t dbus_addr_o,
	input cpu_pkg::word_t      dbus_wdata_o
);

	// a waiting request keeps its address until ready
	ibus_hold: assert property (@(posedge clk) disable iff (reset)
		ibus_valid_o && !ibus_ready_i |=> ibus_valid_o && $stable(ibus_addr_o))
		else $error("instruction bus request changed before ready");

	dbus_hold: assert property (@(posedge clk) disable iff (reset)
		dbus_valid_o && !dbus_ready_i |=>
			dbus_valid_o && $stable(dbus_addr_o) && $stable(dbus_wdata_o))
		else $error("data bus request changed before ready");

	quiet_in_reset: assert property (@(posedge clk)
		reset |-> !ibus_valid_o && !dbus_valid_o)
		else $error("bus valid high during reset");

	we_needs_valid: assert property (@(posedge clk) disable iff (reset)
		dbus_we_o |-> dbus_valid_o)
		else $error("data bus write enable without valid");

endmodule

/* tests/tb_cpu_core.sv */
// Testbench for the pipeline core; runs the program image and checks each store in order
module tb_cpu_core;

	localparam int          MEM_WORDS   = 256;
	localparam int          IMAGE_WORDS = 512;
	localparam int          EXP_BASE    = 256;
	localparam int          PROG_WORDS  = 55;
	localparam int          TIMEOUT     = 20 * PROG_WORDS + 1000;
	localparam int          RESET_LEN   = 10;
	localparam int          SEED        = 32401;
	localparam logic [31:0] DONE_ADDR   = 32'h0000_03fc;

	logic                clk;
	logic                reset;
	logic                ibus_valid, ibus_ready;
	cpu_pkg::word_addr_t ibus_addr;
	cpu_pkg::word_t      ibus_rdata;
	logic                dbus_valid, dbus_we, dbus_ready;
	cpu_pkg::word_addr_t dbus_addr;
	cpu_pkg::word_t      dbus_wdata, dbus_rdata;

	logic [31:0] image [0:IMAGE_WORDS-1];
	logic [31:0] mem [0:MEM_WORDS-1];
	int          exp_count, store_idx, cycles, reset_count, iwait, dwait;
	logic        first_fetch_seen;

	cpu_core u_cpu_core (
		.clk(clk), .reset(reset),
		.ibus_valid_o(ibus_valid), .ibus_ready_i(ibus_ready),
		.ibus_addr_o(ibus_addr), .ibus_rdata_i(ibus_rdata),
		.dbus_valid_o(dbus_valid), .dbus_we_o(dbus_we), .dbus_ready_i(dbus_ready),
		.dbus_addr_o(dbus_addr), .dbus_wdata_o(dbus_wdata), .dbus_rdata_i(dbus_rdata)
	);

	bind cpu_core cpu_core_assertions u_assertions (
		.clk(clk), .reset(reset),
		.ibus_valid_o(ibus_valid_o), .ibus_ready_i(ibus_ready_i), .ibus_addr_o(ibus_addr_o),
		.dbus_valid_o(dbus_valid_o), .dbus_we_o(dbus_we_o), .dbus_ready_i(dbus_ready_i),
		.dbus_addr_o(dbus_addr_o), .dbus_wdata_o(dbus_wdata_o)
	);

	// ------------------------------------------------------------------------
	task automatic fail_run(input string why);
		$display("%s", why);
		$display("*** TEST FAILED ***");
		$fatal(1, "run stopped");
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
	                           input logic [31:0] exp);
		if (got !== exp) begin
			$display("ERROR %s: got %h, expected %h", name, got, exp);
			fail_run("a checked value did not match");
		end
	endtask

	// entries up to and including the store to the done address
	function automatic int count_expected();
		for (int k = 0; k < (IMAGE_WORDS - EXP_BASE) / 2; k++) begin
			if (image[EXP_BASE + 2 * k] === DONE_ADDR) begin
				return k + 1;
			end
		end
		return 0;
	endfunction

	task automatic record_store(input logic [31:0] addr, input logic [31:0] data);
		check_value("dbus_addr_o", addr, image[EXP_BASE + 2 * store_idx]);
		check_value("dbus_wdata_o", data, image[EXP_BASE + 2 * store_idx + 1]);
		store_idx++;
		// last entry is the store to the done address
		if (store_idx == exp_count) begin
			$display("*** TEST PASSED ***");
			$finish;
		end
	endtask

	// ------------------------------------------------------------------------
	// memory models, ready after 0 to 3 idle cycles
	task automatic serve_ibus();
		if (ibus_valid && !first_fetch_seen) begin
			check_value("ibus_addr_o", {ibus_addr, 2'b00}, cpu_pkg::RESET_VECTOR);
			first_fetch_seen = 1'b1;
		end
		if (ibus_valid && iwait == 0) begin
			ibus_ready = 1'b1;
			ibus_rdata = mem[ibus_addr[7:0]];
			iwait      = $urandom % 4;
		end else begin
			ibus_ready = 1'b0;
			if (ibus_valid) begin
				iwait--;
			end
		end
	endtask

	// valid comes from registers only, so a ready set here completes at the next edge
	task automatic serve_dbus();
		if (dbus_valid && dwait == 0) begin
			dbus_ready = 1'b1;
			dbus_rdata = mem[dbus_addr[7:0]];
			dwait      = $urandom % 4;
			if (dbus_we) begin
				mem[dbus_addr[7:0]] = dbus_wdata;
				record_store({dbus_addr, 2'b00}, dbus_wdata);
			end
		end else begin
			dbus_ready = 1'b0;
			if (dbus_valid) begin
				dwait--;
			end
		end
	endtask

	initial begin
		forever #50 clk = ~clk;
	end

	initial begin
		clk              = 1'b0;
		void'($urandom(SEED));
		reset            = 1'b1;
		ibus_ready       = 1'b0;
		ibus_rdata       = '0;
		dbus_ready       = 1'b0;
		dbus_rdata       = '0;
		store_idx        = 0;
		cycles           = 0;
		reset_count      = 0;
		iwait            = 0;
		dwait            = 0;
		first_fetch_seen = 1'b0;
		for (int i = 0; i < IMAGE_WORDS; i++) begin
			image[i] = 32'h5a00_0000 | 32'(i);
		end
		$readmemh("tests/program_input.hex", image);
		for (int i = 0; i < MEM_WORDS; i++) begin
			mem[i] = image[i];
		end
		exp_count = count_expected();
		if (exp_count == 0) begin
			fail_run("the expected store list has no store to the done address");
		end

		// all stimulus changes on the falling edge
		forever begin
			@(negedge clk);
			if (reset) begin
				check_value("ibus_valid_o", 32'(ibus_valid), 32'h0);
				check_value("dbus_valid_o", 32'(dbus_valid), 32'h0);
				check_value("dbus_we_o", 32'(dbus_we), 32'h0);
				reset_count++;
				if (reset_count == RESET_LEN) begin
					reset = 1'b0;
				end
			end else begin
				cycles++;
				if (cycles > TIMEOUT) begin
					fail_run("timeout, the program did not reach the done store in time");
				end else begin
					serve_ibus();
					serve_dbus();
				end
			end
		end
	end

endmodule

/* all.f */
hdl/cpu_pkg.sv
hdl/cpu_fetch.sv
hdl/cpu_decode.sv
hdl/cpu_gpr.sv
hdl/cpu_execute.sv
hdl/cpu_memory.sv
hdl/cpu_core.sv
tests/cpu_core_assertions.sv
tests/tb_cpu_core.sv

/* run.sh */
#!/bin/sh
# builds the core and its testbench with Verilator, then runs the simulation
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timing -j 0 \
	--top-module tb_cpu_core \
	-f all.f \
	--Mdir obj_dir -o sim_tb_cpu_core

./obj_dir/sim_tb_cpu_core

/* tests/program_input.hex */
// word image: @000 program, @080 initial data (byte 0x200), @100 expected stores
// expected stores are pairs of byte address and data, the last one to the done address 0x3fc
@000
24010123 3C028000 344200F0 00221821 AC030100 00222023 00622824 AC040104
AC050108 00223025 00223826 00224027 0041482A 0041502B AC06010C AC070110
AC080114 AC090118 AC0A011C 284BFFFF 2C2CFFFF 304DFFFF 382EFFFF 242FFEDC
AC0B0120 AC0C0124 AC0D0128 AC0E012C AC0F0130 8C100200 24110005 02119021
AC120134 10210002 AC000140 AC000140 14210001 AC010138 14220002 AC000140
AC000140 10220001 0800002D AC000140 AC000140 0C000031 AC1F013C 08000034
AC000140 03E00008 AC000140 AC000140 2413600D AC1303FC 08000036
@080
13572468
@100
00000100 80000213 00000104 80000033
00000108 80000010 0000010C 800001F3
00000110 800001D3 00000114 7FFFFE0C
00000118 00000001 0000011C 00000000
00000120 00000001 00000124 00000001
00000128 000000F0 0000012C 0000FEDC
00000130 FFFFFFFF 00000134 1357246D
00000138 00000123 0000013C 000000B8
000003FC 0000600D
